//--- hw/usb3_defines.svh
////////////////////////////////////////////////////////////
// PIPE symbols, training counts and strap values
// counts fit the 4-bit os counter and the 10-bit timer
////////////////////////////////////////////////////////////

`ifndef USB3_DEFINES_SVH
`define USB3_DEFINES_SVH

// pipe word, 32-bit sdr
`define PIPE_W				32
`define PIPE_K_W			4

// 8b/10b symbols
`define SYM_COM				8'hBC
`define SYM_TS1_ID			8'h4A
`define SYM_TS2_ID			8'h45
`define OS_DATAK			4'b0001		// only byte 0 is a k-symbol

// training
`define TS1_COUNT			4'd8		// consecutive sets before moving on
`define TS2_COUNT			4'd8
`define POLL_TIMEOUT		10'd200		// cycles per polling state

// tx margin
`define STRAP_TX_MARGIN		3'b011		// ssc disable, sampled by phy in reset
`define TX_MARGIN_NORMAL	3'b000

`endif

//--- hw/usb3_pkg.sv
////////////////////////////////////////////////////////////
// shared enums; power_state_e follows PIPE power-down coding
////////////////////////////////////////////////////////////

`default_nettype none

package usb3_pkg;

	typedef enum logic [2:0] {
		ST_DETECT		= 3'd0,
		ST_POWER_UP		= 3'd1,
		ST_POLL_TS1		= 3'd2,
		ST_POLL_TS2		= 3'd3,
		ST_U0			= 3'd4,
		ST_POWER_DOWN	= 3'd5
	} ltssm_state_e;

	typedef enum logic [1:0] {SEL_IDLE, SEL_TS1, SEL_TS2, SEL_DATA} os_sel_e;

	typedef enum logic [1:0] {P0 = 2'd0, P1 = 2'd1, P2 = 2'd2, P3 = 2'd3} power_state_e;

endpackage

`default_nettype wire

//--- hw/pipe_reset_strap.sv
////////////////////////////////////////////////////////////
// core reset leaves two cycles after rst_n and pwrpresent
// strap margin is only valid while core_rst_n is low
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module pipe_reset_strap (
	input  wire				phy_pipe_half_clk,
	input  wire				rst_n,
	input  wire				phy_pwrpresent,
	output logic			core_rst_n,
	output logic			phy_reset_n,
	output logic			phy_phy_reset_n,
	input  wire		[2:0]	tx_margin_run,
	output logic	[2:0]	phy_tx_margin
);

	logic	local_rst_n;
	logic	rst_meta;				// first sync stage

	assign local_rst_n = rst_n & phy_pwrpresent;

	always_ff @(posedge phy_pipe_half_clk) begin
		rst_meta <= local_rst_n;
		core_rst_n <= rst_meta;
	end

	assign phy_reset_n = rst_n;				// full phy reset loses pll lock
	assign phy_phy_reset_n = local_rst_n;	// cable pull resets phy with the core

	// strap value is latched by the phy while we hold reset
	assign phy_tx_margin = core_rst_n ? tx_margin_run : `STRAP_TX_MARGIN;

	a_pwr_loss: assert property (@(posedge phy_pipe_half_clk)
		!phy_pwrpresent && !$past(phy_pwrpresent) |=> !core_rst_n);

endmodule

`default_nettype wire

//--- hw/ltssm_timer.sv
////////////////////////////////////////////////////////////
// restarts on any state change, saturates at POLL_TIMEOUT
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module ltssm_timer (
	input  wire							phy_pipe_half_clk,
	input  wire							core_rst_n,
	input  wire usb3_pkg::ltssm_state_e	state,
	output logic						expired
);

	usb3_pkg::ltssm_state_e	state_q;
	logic	[9:0]			cnt;
	logic					same_state;

	assign same_state = (state == state_q);

	always_ff @(posedge phy_pipe_half_clk) begin
		if (!core_rst_n) begin
			state_q <= usb3_pkg::ST_DETECT;
			cnt <= '0;
		end else begin
			state_q <= state;
			if (!same_state)
				cnt <= 10'd1;				// the change cycle counts too
			else if (cnt != `POLL_TIMEOUT)
				cnt <= cnt + 10'd1;
		end
	end

	// masked on the change cycle so an old count never leaks through
	assign expired = same_state && (cnt == `POLL_TIMEOUT);

endmodule

`default_nettype wire

//--- hw/pipe_power_ctrl.sv
////////////////////////////////////////////////////////////
// four-phase power-down handshake, one request at a time
// phy_phy_status is taken as the phy's done pulse
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module pipe_power_ctrl (
	input  wire							phy_pipe_half_clk,
	input  wire							core_rst_n,
	input  wire							power_req,
	input  wire usb3_pkg::power_state_e	power_target,
	output logic						power_ack,
	output usb3_pkg::power_state_e		phy_power_down,
	input  wire							phy_phy_status
);

	localparam logic [1:0]	PH_IDLE = 2'd0;
	localparam logic [1:0]	PH_WAIT = 2'd1;		// new state driven, phy busy
	localparam logic [1:0]	PH_ACK  = 2'd2;

	logic	[1:0]	phase;

	always_ff @(posedge phy_pipe_half_clk) begin
		if (!core_rst_n) begin
			phase <= PH_IDLE;
			phy_power_down <= usb3_pkg::P2;
		end else begin
			case (phase)
				PH_IDLE: if (power_req) begin
					phy_power_down <= power_target;
					phase <= PH_WAIT;
				end
				PH_WAIT: if (phy_phy_status) phase <= PH_ACK;
				PH_ACK:  if (!power_req) phase <= PH_IDLE;	// req dropped, close
				default: phase <= PH_IDLE;
			endcase
		end
	end

	assign power_ack = (phase == PH_ACK);

	a_ack_needs_req: assert property (@(posedge phy_pipe_half_clk) disable iff (!core_rst_n)
		$rose(power_ack) |-> power_req);

	// target may only move once the requester has let go
	a_target_stable: assert property (@(posedge phy_pipe_half_clk) disable iff (!core_rst_n)
		power_req && $past(power_req) |-> $stable(power_target));

endmodule

`default_nettype wire

//--- hw/ltssm_fsm.sv
////////////////////////////////////////////////////////////
// reduced link training, no recovery and no U1/U2/U3
// polling timeout always falls back through P2 to detect
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module ltssm_fsm (
	input  wire							phy_pipe_half_clk,
	input  wire							core_rst_n,
	input  wire							phy_rx_elecidle,
	input  wire							expired,
	input  wire							ts1_done,
	input  wire							ts2_done,
	input  wire							power_ack,
	output logic						power_req,
	output usb3_pkg::power_state_e		power_target,
	output usb3_pkg::os_sel_e			os_sel,
	output usb3_pkg::ltssm_state_e		state,
	output logic						phy_tx_elecidle,
	output logic	[2:0]				tx_margin_run
);

	usb3_pkg::ltssm_state_e	state_nxt;
	logic					req_nxt;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		req_nxt = power_req;
		case (state)
			usb3_pkg::ST_DETECT: begin
				if (!phy_rx_elecidle) state_nxt = usb3_pkg::ST_POWER_UP;	// partner seen
			end
			usb3_pkg::ST_POWER_UP, usb3_pkg::ST_POWER_DOWN: begin
				if (!power_req && !power_ack) begin
					req_nxt = 1'b1;		// wait for any old ack to clear first
				end else if (power_req && power_ack) begin
					req_nxt = 1'b0;
					if (state == usb3_pkg::ST_POWER_UP)
						state_nxt = usb3_pkg::ST_POLL_TS1;
					else
						state_nxt = usb3_pkg::ST_DETECT;
				end
			end
			usb3_pkg::ST_POLL_TS1: begin
				if (ts1_done) state_nxt = usb3_pkg::ST_POLL_TS2;
				else if (expired) state_nxt = usb3_pkg::ST_POWER_DOWN;
			end
			usb3_pkg::ST_POLL_TS2: begin
				if (ts2_done) state_nxt = usb3_pkg::ST_U0;
				else if (expired) state_nxt = usb3_pkg::ST_POWER_DOWN;
			end
			usb3_pkg::ST_U0: begin
				if (phy_rx_elecidle) state_nxt = usb3_pkg::ST_POWER_DOWN;	// partner gone
			end
			default: state_nxt = usb3_pkg::ST_DETECT;
		endcase
	end

	always_ff @(posedge phy_pipe_half_clk) begin
		if (!core_rst_n) begin
			state <= usb3_pkg::ST_DETECT;
			power_req <= 1'b0;
		end else begin
			state <= state_nxt;
			power_req <= req_nxt;
		end
	end

	////////////////////////////////////////////////////////////
	// outputs, decoded from state
	////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			usb3_pkg::ST_POLL_TS1: os_sel = usb3_pkg::SEL_TS1;
			usb3_pkg::ST_POLL_TS2: os_sel = usb3_pkg::SEL_TS2;
			usb3_pkg::ST_U0:       os_sel = usb3_pkg::SEL_DATA;
			default:               os_sel = usb3_pkg::SEL_IDLE;
		endcase
	end

	always_comb begin
		if (state == usb3_pkg::ST_POWER_UP)
			power_target = usb3_pkg::P0;
		else
			power_target = usb3_pkg::P2;		// power down, also the idle value
	end

	assign phy_tx_elecidle = (os_sel == usb3_pkg::SEL_IDLE);	// quiet outside polling and U0
	assign tx_margin_run = `TX_MARGIN_NORMAL;

	a_state_legal: assert property (@(posedge phy_pipe_half_clk) disable iff (!core_rst_n)
		state inside {usb3_pkg::ST_DETECT, usb3_pkg::ST_POWER_UP, usb3_pkg::ST_POLL_TS1,
			usb3_pkg::ST_POLL_TS2, usb3_pkg::ST_U0, usb3_pkg::ST_POWER_DOWN});

endmodule

`default_nettype wire

//--- hw/ordered_set_unit.sv
////////////////////////////////////////////////////////////
// no back-pressure, link side takes a word every cycle
// TS words are COM plus three id bytes, no config fields
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module ordered_set_unit (
	input  wire							phy_pipe_half_clk,
	input  wire							core_rst_n,
	input  wire usb3_pkg::os_sel_e		os_sel,
	input  wire		[`PIPE_W-1:0]		phy_pipe_rx_data,
	input  wire		[`PIPE_K_W-1:0]		phy_pipe_rx_datak,
	input  wire							phy_pipe_rx_valid,
	output logic						ts1_done,
	output logic						ts2_done,
	output logic	[`PIPE_W-1:0]		phy_pipe_tx_data,
	output logic	[`PIPE_K_W-1:0]		phy_pipe_tx_datak,
	input  wire		[`PIPE_W-1:0]		link_tx_data,
	output logic	[`PIPE_W-1:0]		link_rx_data,
	output logic						link_rx_valid
);

	localparam logic [`PIPE_W-1:0]	TS1_WORD = {{3{`SYM_TS1_ID}}, `SYM_COM};
	localparam logic [`PIPE_W-1:0]	TS2_WORD = {{3{`SYM_TS2_ID}}, `SYM_COM};

	usb3_pkg::os_sel_e		sel_q;
	logic	[3:0]			os_cnt;
	logic	[3:0]			cnt_goal;
	logic	[`PIPE_W-1:0]	exp_word;
	logic					training;
	logic					sel_same;
	logic					os_hit;

	assign training = (os_sel == usb3_pkg::SEL_TS1) || (os_sel == usb3_pkg::SEL_TS2);
	assign exp_word = (os_sel == usb3_pkg::SEL_TS2) ? TS2_WORD : TS1_WORD;
	assign cnt_goal = (os_sel == usb3_pkg::SEL_TS2) ? `TS2_COUNT : `TS1_COUNT;
	assign sel_same = (os_sel == sel_q);
	assign os_hit = phy_pipe_rx_valid && training && (phy_pipe_rx_data == exp_word)
		&& (phy_pipe_rx_datak == `OS_DATAK);

	////////////////////////////////////////////////////////////
	// rx ordered-set counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge phy_pipe_half_clk) begin
		if (!core_rst_n) begin
			sel_q <= usb3_pkg::SEL_IDLE;
			os_cnt <= '0;
		end else begin
			sel_q <= os_sel;
			if (!sel_same)
				os_cnt <= {3'd0, os_hit};			// first word of a new phase counts
			else if (phy_pipe_rx_valid && os_cnt != cnt_goal)
				os_cnt <= os_hit ? os_cnt + 4'd1 : 4'd0;	// must be consecutive
		end
	end

	// held at the goal until os_sel moves on
	assign ts1_done = sel_same && (os_sel == usb3_pkg::SEL_TS1) && (os_cnt == `TS1_COUNT);
	assign ts2_done = sel_same && (os_sel == usb3_pkg::SEL_TS2) && (os_cnt == `TS2_COUNT);

	////////////////////////////////////////////////////////////
	// tx word and link rx
	////////////////////////////////////////////////////////////

	always_ff @(posedge phy_pipe_half_clk) begin
		if (!core_rst_n) begin
			phy_pipe_tx_data <= '0;
			phy_pipe_tx_datak <= '0;
			link_rx_valid <= 1'b0;
		end else begin
			case (os_sel)
				usb3_pkg::SEL_TS1:  {phy_pipe_tx_datak, phy_pipe_tx_data} <= {`OS_DATAK, TS1_WORD};
				usb3_pkg::SEL_TS2:  {phy_pipe_tx_datak, phy_pipe_tx_data} <= {`OS_DATAK, TS2_WORD};
				usb3_pkg::SEL_DATA: {phy_pipe_tx_datak, phy_pipe_tx_data} <= {4'b0000, link_tx_data};
				default:            {phy_pipe_tx_datak, phy_pipe_tx_data} <= '0;
			endcase
			link_rx_valid <= phy_pipe_rx_valid && (os_sel == usb3_pkg::SEL_DATA);	// U0 only
		end
	end

	always_ff @(posedge phy_pipe_half_clk) link_rx_data <= phy_pipe_rx_data;

	a_done_excl: assert property (@(posedge phy_pipe_half_clk) disable iff (!core_rst_n)
		!(ts1_done && ts2_done));

endmodule

`default_nettype wire

//--- hw/usb3_pipe_top.sv
////////////////////////////////////////////////////////////
// PIPE bring-up front end, one clock domain
// rx_elecidle and phy_status are plain inputs, no straps on them
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module usb3_pipe_top (
	input  wire							phy_pipe_half_clk,
	input  wire							rst_n,
	input  wire							phy_pwrpresent,
	input  wire							phy_rx_elecidle,
	input  wire							phy_phy_status,
	input  wire		[`PIPE_W-1:0]		phy_pipe_rx_data,
	input  wire		[`PIPE_K_W-1:0]		phy_pipe_rx_datak,
	input  wire							phy_pipe_rx_valid,
	input  wire		[`PIPE_W-1:0]		link_tx_data,
	output logic						phy_reset_n,
	output logic						phy_phy_reset_n,
	output logic	[2:0]				phy_tx_margin,
	output logic						phy_tx_elecidle,
	output usb3_pkg::power_state_e		phy_power_down,
	output logic	[`PIPE_W-1:0]		phy_pipe_tx_data,
	output logic	[`PIPE_K_W-1:0]		phy_pipe_tx_datak,
	output logic	[`PIPE_W-1:0]		link_rx_data,
	output logic						link_rx_valid,
	output usb3_pkg::ltssm_state_e		dbg_ltssm_state
);

	logic						core_rst_n;
	logic	[2:0]				tx_margin_run;
	logic						expired;
	logic						ts1_done;
	logic						ts2_done;
	logic						power_req;
	logic						power_ack;
	usb3_pkg::power_state_e		power_target;
	usb3_pkg::os_sel_e			os_sel;

	////////////////////////////////////////////////////////////
	// reset and straps
	////////////////////////////////////////////////////////////

	pipe_reset_strap u_reset_strap (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.rst_n				(rst_n),
		.phy_pwrpresent		(phy_pwrpresent),
		.core_rst_n			(core_rst_n),
		.phy_reset_n		(phy_reset_n),
		.phy_phy_reset_n	(phy_phy_reset_n),
		.tx_margin_run		(tx_margin_run),
		.phy_tx_margin		(phy_tx_margin)
	);

	////////////////////////////////////////////////////////////
	// training, power and data path
	////////////////////////////////////////////////////////////

	ltssm_fsm u_fsm (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.core_rst_n			(core_rst_n),
		.phy_rx_elecidle	(phy_rx_elecidle),
		.expired			(expired),
		.ts1_done			(ts1_done),
		.ts2_done			(ts2_done),
		.power_ack			(power_ack),
		.power_req			(power_req),
		.power_target		(power_target),
		.os_sel				(os_sel),
		.state				(dbg_ltssm_state),
		.phy_tx_elecidle	(phy_tx_elecidle),
		.tx_margin_run		(tx_margin_run)
	);

	ltssm_timer u_timer (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.core_rst_n			(core_rst_n),
		.state				(dbg_ltssm_state),
		.expired			(expired)
	);

	pipe_power_ctrl u_power (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.core_rst_n			(core_rst_n),
		.power_req			(power_req),
		.power_target		(power_target),
		.power_ack			(power_ack),
		.phy_power_down		(phy_power_down),
		.phy_phy_status		(phy_phy_status)
	);

	ordered_set_unit u_os (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.core_rst_n			(core_rst_n),
		.os_sel				(os_sel),
		.phy_pipe_rx_data	(phy_pipe_rx_data),
		.phy_pipe_rx_datak	(phy_pipe_rx_datak),
		.phy_pipe_rx_valid	(phy_pipe_rx_valid),
		.ts1_done			(ts1_done),
		.ts2_done			(ts2_done),
		.phy_pipe_tx_data	(phy_pipe_tx_data),
		.phy_pipe_tx_datak	(phy_pipe_tx_datak),
		.link_tx_data		(link_tx_data),
		.link_rx_data		(link_rx_data),
		.link_rx_valid		(link_rx_valid)
	);

endmodule

`default_nettype wire

//--- test/tb_usb3_pipe_top.sv
////////////////////////////////////////////////////////////
// link partner and phy model around usb3_pipe_top
// random stimulus from seed 81
// phy_status is a one-cycle pulse 1 to 5 cycles after a change
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "usb3_defines.svh"

module tb_usb3_pipe_top;

	// room for three polling timeouts plus training and data
	localparam int CYCLE_LIMIT = 20000;
	localparam int TIMEOUT_EDGES = int'(`POLL_TIMEOUT) + 1;	// one more edge after expired to move
	localparam int MIX_WORDS = 24;		// words that may carry junk before a clean run
	localparam int TRAIN_LIMIT = 48;
	localparam logic [31:0] TS1_PAT = {`SYM_TS1_ID, `SYM_TS1_ID, `SYM_TS1_ID, `SYM_COM};
	localparam logic [31:0] TS2_PAT = {`SYM_TS2_ID, `SYM_TS2_ID, `SYM_TS2_ID, `SYM_COM};

	logic					phy_pipe_half_clk = 1'b0;
	logic					rst_n;
	logic					phy_pwrpresent;
	logic					phy_rx_elecidle;
	logic					phy_phy_status;
	logic	[31:0]			phy_pipe_rx_data;
	logic	[3:0]			phy_pipe_rx_datak;
	logic					phy_pipe_rx_valid;
	logic	[31:0]			link_tx_data;
	logic					phy_reset_n;
	logic					phy_phy_reset_n;
	logic	[2:0]			phy_tx_margin;
	logic					phy_tx_elecidle;
	usb3_pkg::power_state_e	phy_power_down;
	logic	[31:0]			phy_pipe_tx_data;
	logic	[3:0]			phy_pipe_tx_datak;
	logic	[31:0]			link_rx_data;
	logic					link_rx_valid;
	usb3_pkg::ltssm_state_e	dbg_ltssm_state;

	string					test_name;
	int						test_errs;
	int						pass_cnt;
	int						fail_cnt;
	int						cycle_cnt;
	logic					partner_on;
	usb3_pkg::power_state_e	pd_seen;

	usb3_pipe_top u_dut (
		.phy_pipe_half_clk	(phy_pipe_half_clk),
		.rst_n				(rst_n),
		.phy_pwrpresent		(phy_pwrpresent),
		.phy_rx_elecidle	(phy_rx_elecidle),
		.phy_phy_status		(phy_phy_status),
		.phy_pipe_rx_data	(phy_pipe_rx_data),
		.phy_pipe_rx_datak	(phy_pipe_rx_datak),
		.phy_pipe_rx_valid	(phy_pipe_rx_valid),
		.link_tx_data		(link_tx_data),
		.phy_reset_n		(phy_reset_n),
		.phy_phy_reset_n	(phy_phy_reset_n),
		.phy_tx_margin		(phy_tx_margin),
		.phy_tx_elecidle	(phy_tx_elecidle),
		.phy_power_down		(phy_power_down),
		.phy_pipe_tx_data	(phy_pipe_tx_data),
		.phy_pipe_tx_datak	(phy_pipe_tx_datak),
		.link_rx_data		(link_rx_data),
		.link_rx_valid		(link_rx_valid),
		.dbg_ltssm_state	(dbg_ltssm_state)
	);

	always #4 phy_pipe_half_clk = ~phy_pipe_half_clk;		// 8 ns

	always @(posedge phy_pipe_half_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, DUT did not finish in time", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic step_cycle();
		@(posedge phy_pipe_half_clk);
		#1;									// outputs settled and inputs change here
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("[PASS] %s", test_name);
			pass_cnt++;
		end else begin
			$display("[FAIL] %s, %0d errors", test_name, test_errs);
			fail_cnt++;
		end
	endtask

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic wait_for_state(input usb3_pkg::ltssm_state_e target, input int limit);
		int n;
		n = 0;
		while (dbg_ltssm_state !== target && n < limit) begin
			step_cycle();
			n++;
		end
		if (dbg_ltssm_state !== target) begin
			$display("%s: state %0d not reached within %0d cycles, DUT is in state %0d",
				test_name, target, limit, dbg_ltssm_state);
			test_errs++;
		end
	endtask

	// partner sends ordered sets with junk mixed in
	// count model predicts the exit edge
	task automatic train_phase(input logic [31:0] os_word, input usb3_pkg::ltssm_state_e cur_st,
		input usb3_pkg::ltssm_state_e next_st, input int goal);
		int				cnt;
		int				i;
		int				r;
		logic	[31:0]	rnd;
		logic			hit;
		logic			done;
		cnt = 0;
		i = 0;
		done = 1'b0;
		while (!done && i < TRAIN_LIMIT) begin
			r = $urandom % 8;
			rnd = $urandom;
			if (i >= MIX_WORDS || r >= 2) begin
				phy_pipe_rx_data = os_word;
				phy_pipe_rx_datak = `OS_DATAK;
				phy_pipe_rx_valid = 1'b1;
			end else if (r == 0) begin
				phy_pipe_rx_data = $urandom;		// junk breaks the run
				phy_pipe_rx_datak = rnd[3:0];
				phy_pipe_rx_valid = 1'b1;
			end else begin
				phy_pipe_rx_data = rnd;				// not valid so the count holds
				phy_pipe_rx_datak = 4'h0;
				phy_pipe_rx_valid = 1'b0;
			end
			hit = phy_pipe_rx_valid && (phy_pipe_rx_data == os_word)
				&& (phy_pipe_rx_datak == `OS_DATAK);
			step_cycle();
			if (cnt == goal) begin
				check_val("state at predicted exit", 32'(next_st), 32'(dbg_ltssm_state));
				done = 1'b1;
			end else begin
				check_val("state while training", 32'(cur_st), 32'(dbg_ltssm_state));
			end
			if (phy_pipe_rx_valid && cnt != goal)
				cnt = hit ? cnt + 1 : 0;
			i++;
		end
		if (!done) begin
			$display("%s: model count never reached %0d in %0d words", test_name, goal, i);
			test_errs++;
		end
	endtask

	// phy side of the power handshake
	always begin : phy_partner
		int lat;
		step_cycle();
		if (partner_on && phy_power_down !== pd_seen) begin
			pd_seen = phy_power_down;
			lat = 1 + $urandom % 5;
			repeat (lat - 1) step_cycle();
			phy_phy_status = 1'b1;
			step_cycle();
			phy_phy_status = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int				i;
		logic	[31:0]	tx_w;
		logic	[31:0]	rx_w;
		logic	[31:0]	rnd;
		void'($urandom(81));
		rst_n = 1'b0;
		phy_pwrpresent = 1'b1;
		phy_rx_elecidle = 1'b1;
		phy_phy_status = 1'b0;
		phy_pipe_rx_data = '0;
		phy_pipe_rx_datak = '0;
		phy_pipe_rx_valid = 1'b0;
		link_tx_data = '0;
		cycle_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		partner_on = 1'b0;
		pd_seen = usb3_pkg::P2;

		start_test("reset_strap");
		for (i = 0; i < 16; i++) begin
			step_cycle();
			if (i >= 2)
				check_val("tx margin in reset", 32'(`STRAP_TX_MARGIN), 32'(phy_tx_margin));
			check_val("phy_reset_n", 32'd0, 32'(phy_reset_n));
			check_val("phy_phy_reset_n", 32'd0, 32'(phy_phy_reset_n));
		end
		rst_n = 1'b1;
		step_cycle();
		check_val("tx margin, first cycle out", 32'(`STRAP_TX_MARGIN), 32'(phy_tx_margin));
		check_val("phy_reset_n", 32'd1, 32'(phy_reset_n));
		check_val("phy_phy_reset_n", 32'd1, 32'(phy_phy_reset_n));
		step_cycle();
		check_val("tx margin, running", 32'(`TX_MARGIN_NORMAL), 32'(phy_tx_margin));
		check_val("tx elecidle", 32'd1, 32'(phy_tx_elecidle));
		check_val("power down", 32'(usb3_pkg::P2), 32'(phy_power_down));
		check_val("state", 32'(usb3_pkg::ST_DETECT), 32'(dbg_ltssm_state));
		phy_pwrpresent = 1'b0;				// cable pull
		step_cycle();
		check_val("phy_phy_reset_n, no power", 32'd0, 32'(phy_phy_reset_n));
		check_val("phy_reset_n, no power", 32'd1, 32'(phy_reset_n));
		step_cycle();
		check_val("tx margin, no power", 32'(`STRAP_TX_MARGIN), 32'(phy_tx_margin));
		phy_pwrpresent = 1'b1;
		repeat (2) step_cycle();
		check_val("tx margin, power back", 32'(`TX_MARGIN_NORMAL), 32'(phy_tx_margin));
		partner_on = 1'b1;
		end_test();

		start_test("power_up_ts1_tx");
		phy_rx_elecidle = 1'b0;
		wait_for_state(usb3_pkg::ST_POWER_UP, 4);
		check_val("tx elecidle in power up", 32'd1, 32'(phy_tx_elecidle));
		wait_for_state(usb3_pkg::ST_POLL_TS1, 40);
		check_val("power down after handshake", 32'(usb3_pkg::P0), 32'(phy_power_down));
		check_val("tx elecidle in polling", 32'd0, 32'(phy_tx_elecidle));
		for (i = 1; i <= 16; i++) begin
			step_cycle();
			check_val("state", 32'(usb3_pkg::ST_POLL_TS1), 32'(dbg_ltssm_state));
			check_val("tx data", TS1_PAT, phy_pipe_tx_data);
			check_val("tx datak", 32'(`OS_DATAK), 32'(phy_pipe_tx_datak));
		end
		end_test();

		start_test("poll_timeout");
		for (i = 17; i <= TIMEOUT_EDGES; i++) begin
			step_cycle();
			if (i < TIMEOUT_EDGES)
				check_val("state before timeout", 32'(usb3_pkg::ST_POLL_TS1),
					32'(dbg_ltssm_state));
			else
				check_val("state at timeout", 32'(usb3_pkg::ST_POWER_DOWN),
					32'(dbg_ltssm_state));
		end
		phy_rx_elecidle = 1'b1;				// keep it in detect
		wait_for_state(usb3_pkg::ST_DETECT, 40);
		check_val("power down", 32'(usb3_pkg::P2), 32'(phy_power_down));
		check_val("tx elecidle", 32'd1, 32'(phy_tx_elecidle));
		check_val("tx data", 32'd0, phy_pipe_tx_data);
		end_test();

		start_test("ts_training");
		phy_rx_elecidle = 1'b0;
		wait_for_state(usb3_pkg::ST_POLL_TS1, 40);
		check_val("power down", 32'(usb3_pkg::P0), 32'(phy_power_down));
		train_phase(TS1_PAT, usb3_pkg::ST_POLL_TS1, usb3_pkg::ST_POLL_TS2, int'(`TS1_COUNT));
		train_phase(TS2_PAT, usb3_pkg::ST_POLL_TS2, usb3_pkg::ST_U0, int'(`TS2_COUNT));
		end_test();

		start_test("u0_data");
		for (i = 0; i < 64; i++) begin
			tx_w = $urandom;
			rx_w = $urandom;
			rnd = $urandom;
			link_tx_data = tx_w;
			phy_pipe_rx_data = rx_w;
			phy_pipe_rx_datak = rnd[3:0];
			phy_pipe_rx_valid = rnd[4];
			step_cycle();
			check_val("state", 32'(usb3_pkg::ST_U0), 32'(dbg_ltssm_state));
			check_val("tx data", tx_w, phy_pipe_tx_data);
			check_val("tx datak", 32'd0, 32'(phy_pipe_tx_datak));
			check_val("link rx data", rx_w, link_rx_data);
			check_val("link rx valid", 32'(rnd[4]), 32'(link_rx_valid));
		end
		end_test();

		start_test("elecidle_exit");
		phy_rx_elecidle = 1'b1;
		phy_pipe_rx_valid = 1'b1;			// held high so only the U0 gate can clear valid
		step_cycle();
		check_val("state after elecidle", 32'(usb3_pkg::ST_POWER_DOWN), 32'(dbg_ltssm_state));
		check_val("link rx valid, last U0 word", 32'd1, 32'(link_rx_valid));
		step_cycle();
		check_val("link rx valid out of U0", 32'd0, 32'(link_rx_valid));
		wait_for_state(usb3_pkg::ST_DETECT, 40);
		check_val("power down", 32'(usb3_pkg::P2), 32'(phy_power_down));
		check_val("tx elecidle", 32'd1, 32'(phy_tx_elecidle));
		check_val("link rx valid", 32'd0, 32'(link_rx_valid));
		check_val("tx data", 32'd0, phy_pipe_tx_data);
		phy_pipe_rx_valid = 1'b0;
		end_test();

		$display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/usb3_pkg.sv
hw/pipe_reset_strap.sv
hw/ltssm_timer.sv
hw/pipe_power_ctrl.sv
hw/ltssm_fsm.sv
hw/ordered_set_unit.sv
hw/usb3_pipe_top.sv
test/tb_usb3_pipe_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass is found in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f tb.f --top-module tb_usb3_pipe_top -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
